/* logic/memCtrl_consts.svh */
`ifndef MEM_CTRL_CONSTS_SVH
`define MEM_CTRL_CONSTS_SVH

// byte address width seen by both ports
`define MEM_ADDR_W 16

// bytes of on-chip RAM, a power of two
`define MEM_DEPTH 1024

// load, store and fetch word width
`define MEM_WORD_W 32

`endif

/* logic/memCtrlPkg.sv */
`include "memCtrl_consts.svh"

package memCtrlPkg;

    // number of bytes moved by one request
    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } accessSize;

    // word-level request from the fetch or data side
    typedef struct packed {
        logic                   valid;
        logic                   write;
        accessSize              size;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_WORD_W-1:0] wdata;
    } memReq;

    typedef struct packed {
        logic                   done;
        logic                   busy;
        logic [`MEM_WORD_W-1:0] rdata;
    } memResp;

    // one byte cycle on the RAM
    typedef struct packed {
        logic                   en;
        logic                   write;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [7:0]             wdata;
    } ramCmd;

endpackage

/* logic/memPortArbiter.sv */
`include "memCtrl_consts.svh"

module memPortArbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  memCtrlPkg::memReq      fetchReq,
    input  memCtrlPkg::memReq      dataReq,
    input  logic                   seqDone,
    input  logic [`MEM_WORD_W-1:0] seqRdata,
    output memCtrlPkg::memReq      grantReq,
    output logic                   grantIsData,
    output memCtrlPkg::memResp     fetchResp,
    output memCtrlPkg::memResp     dataResp
);
    typedef enum logic [1:0] {
        arbIdle,
        arbFetch,
        arbData
    } arbState;

    arbState state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= arbIdle;
        end else if (rdy) begin
            case (state)
                arbIdle: begin
                    // data side wins a tie
                    if (dataReq.valid) begin
                        state <= arbData;
                    end else if (fetchReq.valid) begin
                        state <= arbFetch;
                    end
                end
                default: begin
                    if (seqDone) begin
                        state <= arbIdle;
                    end
                end
            endcase
        end
    end

    assign grantIsData = (state == arbData);

    always_comb begin
        case (state)
            arbData: begin
                grantReq = dataReq;
            end
            arbFetch: begin
                // fetch is always a word read
                grantReq       = fetchReq;
                grantReq.write = 1'b0;
                grantReq.size  = memCtrlPkg::sizeWord;
            end
            default: begin
                grantReq = '0;
            end
        endcase
    end

    always_comb begin
        fetchResp.done  = seqDone && (state == arbFetch);
        fetchResp.rdata = (state == arbFetch) ? seqRdata : '0;
        fetchResp.busy  = (state == arbFetch) || (fetchReq.valid && state != arbIdle);
        dataResp.done   = seqDone && grantIsData;
        dataResp.rdata  = grantIsData ? seqRdata : '0;
        dataResp.busy   = grantIsData || (dataReq.valid && state != arbIdle);
    end

endmodule

/* logic/memByteSequencer.sv */
`include "memCtrl_consts.svh"

module memByteSequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  memCtrlPkg::memReq      grantReq,
    input  logic [7:0]             ramRdata,
    output memCtrlPkg::ramCmd      ramCmd,
    output logic                   seqDone,
    output logic [`MEM_WORD_W-1:0] seqRdata
);
    logic [2:0]             stage;
    logic [2:0]             byteCount;
    logic [2:0]             lastStage;
    logic [1:0]             laneSel;
    logic                   active;
    logic                   capture;
    logic [23:0]            asmReg;
    logic [`MEM_WORD_W-1:0] heldWord;

    always_comb begin
        case (grantReq.size)
            memCtrlPkg::sizeByte: begin
                byteCount = 3'd1;
            end
            memCtrlPkg::sizeHalf: begin
                byteCount = 3'd2;
            end
            default: begin
                byteCount = 3'd4;
            end
        endcase
    end

    // loads need one extra stage for the last RAM read to come back
    assign lastStage = grantReq.write ? byteCount - 3'd1 : byteCount;
    assign active    = grantReq.valid && rdy;
    assign seqDone   = active && (stage == lastStage);

    always_comb begin
        ramCmd.en    = active && (stage < byteCount);
        ramCmd.write = grantReq.write;
        ramCmd.addr  = grantReq.addr + `MEM_ADDR_W'(stage);
        ramCmd.wdata = grantReq.wdata[{stage[1:0], 3'b000} +: 8];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= '0;
        end else if (rdy) begin
            if (!grantReq.valid || stage == lastStage) begin
                stage <= '0;
            end else begin
                stage <= stage + 3'd1;
            end
        end
    end

    // byte of stage-1 is on ramRdata now
    assign laneSel = 2'(stage - 3'd1);
    assign capture = active && !grantReq.write && stage != 3'd0 && stage != lastStage;

    always_ff @(posedge clk) begin
        if (capture) begin
            case (laneSel)
                2'd0: begin
                    asmReg[7:0] <= ramRdata;
                end
                2'd1: begin
                    asmReg[15:8] <= ramRdata;
                end
                default: begin
                    asmReg[23:16] <= ramRdata;
                end
            endcase
        end
    end

    assign heldWord = {8'h00, asmReg};

    // last lane straight from the RAM, zero above the access size
    always_comb begin
        for (int i = 0; i < `MEM_WORD_W / 8; i++) begin
            if (grantReq.write) begin
                seqRdata[8*i +: 8] = 8'h00;
            end else if (i + 1 < int'(byteCount)) begin
                seqRdata[8*i +: 8] = heldWord[8*i +: 8];
            end else if (i + 1 == int'(byteCount)) begin
                seqRdata[8*i +: 8] = ramRdata;
            end else begin
                seqRdata[8*i +: 8] = 8'h00;
            end
        end
    end

endmodule

/* logic/byteRam.sv */
`include "memCtrl_consts.svh"

module byteRam #(
    parameter int depth = `MEM_DEPTH
) (
    input  logic              clk,
    input  memCtrlPkg::ramCmd cmd,
    output logic [7:0]        rdata
);
    localparam int idxW = $clog2(depth);

    logic [7:0]      mem [depth];
    logic [idxW-1:0] idx;

    assign idx = idxW'(cmd.addr % depth);

    // read returns the old byte on a write cycle
    always_ff @(posedge clk) begin
        if (cmd.en) begin
            if (cmd.write) begin
                mem[idx] <= cmd.wdata;
            end
            rdata <= mem[idx];
        end
    end

endmodule

/* logic/memSubsystem.sv */
`include "memCtrl_consts.svh"

module memSubsystem (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  memCtrlPkg::memReq  fetchReq,
    input  memCtrlPkg::memReq  dataReq,
    output memCtrlPkg::memResp fetchResp,
    output memCtrlPkg::memResp dataResp
);
    memCtrlPkg::memReq      grantReq;
    logic                   grantIsData;
    logic                   seqDone;
    logic [`MEM_WORD_W-1:0] seqRdata;
    memCtrlPkg::ramCmd      ramCmd;
    logic [7:0]             ramRdata;

    memPortArbiter arbiter (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .fetchReq    (fetchReq),
        .dataReq     (dataReq),
        .seqDone     (seqDone),
        .seqRdata    (seqRdata),
        .grantReq    (grantReq),
        .grantIsData (grantIsData),
        .fetchResp   (fetchResp),
        .dataResp    (dataResp)
    );

    memByteSequencer sequencer (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .grantReq (grantReq),
        .ramRdata (ramRdata),
        .ramCmd   (ramCmd),
        .seqDone  (seqDone),
        .seqRdata (seqRdata)
    );

    byteRam ram (
        .clk   (clk),
        .cmd   (ramCmd),
        .rdata (ramRdata)
    );

endmodule

/* verification/clockGen.sv */
module clockGen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset over 16 rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* verification/memSubsystem_sva.sv */
module memSubsystemSva (
    input logic               clk,
    input logic               rst,
    input memCtrlPkg::memReq  fetchReq,
    input memCtrlPkg::memReq  dataReq,
    input memCtrlPkg::memResp fetchResp,
    input memCtrlPkg::memResp dataResp,
    input memCtrlPkg::memReq  grantReq,
    input logic               grantIsData,
    input memCtrlPkg::ramCmd  ramCmd
);
    fetchDoneWithValid: assert property (@(posedge clk) disable iff (rst)
        fetchResp.done |-> fetchReq.valid)
        else $error("fetch done raised without a fetch request");

    dataDoneWithValid: assert property (@(posedge clk) disable iff (rst)
        dataResp.done |-> dataReq.valid)
        else $error("data done raised without a data request");

    // done is a one-cycle pulse
    fetchDonePulse: assert property (@(posedge clk) disable iff (rst)
        fetchResp.done |=> !fetchResp.done)
        else $error("fetch done held for two cycles");

    dataDonePulse: assert property (@(posedge clk) disable iff (rst)
        dataResp.done |=> !dataResp.done)
        else $error("data done held for two cycles");

    ramWriteOwned: assert property (@(posedge clk) disable iff (rst)
        (ramCmd.en && ramCmd.write) |-> (grantIsData && grantReq.write))
        else $error("RAM written without an owned data store");

endmodule

bind memSubsystem memSubsystemSva handshakeChecks (
    .clk         (clk),
    .rst         (rst),
    .fetchReq    (fetchReq),
    .dataReq     (dataReq),
    .fetchResp   (fetchResp),
    .dataResp    (dataResp),
    .grantReq    (grantReq),
    .grantIsData (grantIsData),
    .ramCmd      (ramCmd)
);

/* verification/memSubsystemTb.sv */
`include "memCtrl_consts.svh"

module memSubsystemTb;
    localparam int idxW = $clog2(`MEM_DEPTH);

    typedef struct packed {
        logic                   isData;
        logic                   write;
        memCtrlPkg::accessSize  size;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_WORD_W-1:0] wdata;
        logic [3:0]             stall;
        logic                   collide;
    } stimEntry;

    logic               clk;
    logic               rst;
    logic               rdy;
    memCtrlPkg::memReq  fetchReq;
    memCtrlPkg::memReq  dataReq;
    memCtrlPkg::memResp fetchResp;
    memCtrlPkg::memResp dataResp;

    stimEntry   stimTable[$];
    logic [7:0] refMem [`MEM_DEPTH];
    int         valueErrors;
    int         otherErrors;
    int         cycleCount;
    int         cycleLimit;

    clockGen clocks (.clk(clk), .rst(rst));

    memSubsystem DUT (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .fetchReq  (fetchReq),
        .dataReq   (dataReq),
        .fetchResp (fetchResp),
        .dataResp  (dataResp)
    );

    function automatic void flagMismatch(input string what);
        valueErrors++;
        $display("FAIL %0t: %s", $time, what);
    endfunction

    // fetches are always words
    function automatic int byteCount(input stimEntry e);
        if (!e.isData || e.size == memCtrlPkg::sizeWord) begin
            return 4;
        end
        return (e.size == memCtrlPkg::sizeHalf) ? 2 : 1;
    endfunction

    // little-endian, zero above the access size
    function automatic logic [31:0] modelRead(input logic [`MEM_ADDR_W-1:0] addr, input int n);
        logic [31:0] word;
        word = '0;
        for (int k = 0; k < n; k++) begin
            word[8*k +: 8] = refMem[idxW'((int'(addr) + k) % `MEM_DEPTH)];
        end
        return word;
    endfunction

    function automatic void modelWrite(input logic [`MEM_ADDR_W-1:0] addr, input int n,
                                       input logic [31:0] data);
        for (int k = 0; k < n; k++) begin
            refMem[idxW'((int'(addr) + k) % `MEM_DEPTH)] = data[8*k +: 8];
        end
    endfunction

    function automatic stimEntry makeEntry(input logic isData, input logic write,
                                           input memCtrlPkg::accessSize size,
                                           input logic [`MEM_ADDR_W-1:0] addr,
                                           input int stall, input logic collide);
        stimEntry e;
        e.isData  = isData;
        e.write   = write;
        e.size    = size;
        e.addr    = addr;
        e.wdata   = $urandom;
        e.stall   = 4'(stall);
        e.collide = collide;
        return e;
    endfunction

    task automatic buildTable();
        logic [`MEM_ADDR_W-1:0] a;
        memCtrlPkg::accessSize  sz;
        // fill the test window with words
        for (int i = 0; i < 16; i++) begin
            a = 16'(32'h200 + 4 * i);
            stimTable.push_back(makeEntry(1'b1, 1'b1, memCtrlPkg::sizeWord, a, 0, 1'b0));
        end
        stimTable.push_back(makeEntry(1'b1, 1'b1, memCtrlPkg::sizeByte, 16'h0211, 0, 1'b0));
        stimTable.push_back(makeEntry(1'b1, 1'b0, memCtrlPkg::sizeByte, 16'h0211, 0, 1'b0));
        stimTable.push_back(makeEntry(1'b1, 1'b1, memCtrlPkg::sizeHalf, 16'h0216, 0, 1'b0));
        stimTable.push_back(makeEntry(1'b1, 1'b0, memCtrlPkg::sizeHalf, 16'h0216, 0, 1'b0));
        stimTable.push_back(makeEntry(1'b1, 1'b1, memCtrlPkg::sizeWord, 16'h021c, 0, 1'b0));
        stimTable.push_back(makeEntry(1'b1, 1'b0, memCtrlPkg::sizeWord, 16'h021c, 0, 1'b0));
        // separate bytes read back as one word, then a half across a word edge
        for (int i = 0; i < 4; i++) begin
            a = 16'(32'h220 + i);
            stimTable.push_back(makeEntry(1'b1, 1'b1, memCtrlPkg::sizeByte, a, 0, 1'b0));
        end
        stimTable.push_back(makeEntry(1'b1, 1'b0, memCtrlPkg::sizeWord, 16'h0220, 0, 1'b0));
        stimTable.push_back(makeEntry(1'b1, 1'b0, memCtrlPkg::sizeHalf, 16'h0223, 0, 1'b0));
        stimTable.push_back(makeEntry(1'b0, 1'b0, memCtrlPkg::sizeWord, 16'h0200, 0, 1'b0));
        stimTable.push_back(makeEntry(1'b0, 1'b0, memCtrlPkg::sizeWord, 16'h0208, 0, 1'b0));
        stimTable.push_back(makeEntry(1'b0, 1'b0, memCtrlPkg::sizeWord, 16'h023c, 0, 1'b0));
        stimTable.push_back(makeEntry(1'b1, 1'b1, memCtrlPkg::sizeWord, 16'h0228, 0, 1'b1));
        stimTable.push_back(makeEntry(1'b1, 1'b0, memCtrlPkg::sizeHalf, 16'h0205, 0, 1'b1));
        // rdy dropped mid-transfer
        stimTable.push_back(makeEntry(1'b1, 1'b0, memCtrlPkg::sizeWord, 16'h0230, 3, 1'b0));
        stimTable.push_back(makeEntry(1'b1, 1'b1, memCtrlPkg::sizeWord, 16'h0234, 2, 1'b0));
        stimTable.push_back(makeEntry(1'b0, 1'b0, memCtrlPkg::sizeWord, 16'h0238, 4, 1'b0));
        stimTable.push_back(makeEntry(1'b1, 1'b0, memCtrlPkg::sizeHalf, 16'h0213, 1, 1'b0));
        // above the RAM size, wraps onto 0x210
        stimTable.push_back(makeEntry(1'b1, 1'b0, memCtrlPkg::sizeWord, 16'h0610, 0, 1'b0));
        for (int i = 0; i < 12; i++) begin
            a  = 16'(32'h200 + $urandom_range(0, 60));
            sz = memCtrlPkg::accessSize'($urandom_range(0, 2));
            if ($urandom_range(0, 3) == 0) begin
                stimTable.push_back(makeEntry(1'b0, 1'b0, memCtrlPkg::sizeWord, a, 0, 1'b0));
            end else begin
                stimTable.push_back(makeEntry(1'b1, 1'($urandom_range(0, 1)), sz, a, 0, 1'b0));
            end
        end
    endtask

    // sample first, then drive rdy for the next edge
    task automatic awaitDone(input logic isData, input int stall, input logic watchFetch,
                             output int cycles, output logic [31:0] rdata);
        memCtrlPkg::memResp own;
        memCtrlPkg::memResp other;
        logic               seen;
        seen   = 1'b0;
        cycles = 0;
        rdata  = '0;
        while (!seen && cycles < stall + 20) begin
            @(negedge clk);
            cycles++;
            own   = isData ? dataResp : fetchResp;
            other = isData ? fetchResp : dataResp;
            assert (own.busy && !other.done) else flagMismatch("owner not busy or other port done");
            if (watchFetch) begin
                assert (fetchResp.busy) else flagMismatch("waiting fetch not busy");
            end
            if (own.done) begin
                seen  = 1'b1;
                rdata = own.rdata;
            end
            // stall once the first byte is in flight
            rdy = !(cycles > 1 && cycles <= stall + 1);
        end
        rdy = 1'b1;
        assert (seen) else begin
            otherErrors++;
            $display("%s port never raised done", isData ? "data" : "fetch");
        end
    endtask

    task automatic runTransfer(input stimEntry e);
        memCtrlPkg::memReq req;
        memCtrlPkg::memReq fetchSide;
        logic [31:0]       expData;
        logic [31:0]       gotData;
        int                n;
        int                cycles;
        int                expCycles;
        n         = byteCount(e);
        req       = '0;
        req.valid = 1'b1;
        req.write = e.write;
        req.size  = e.size;
        req.addr  = e.addr;
        req.wdata = e.wdata;
        expData   = e.write ? 32'h0 : modelRead(e.addr, n);
        expCycles = n + (e.write ? 0 : 1) + int'(e.stall);
        if (e.isData) begin
            dataReq = req;
        end else begin
            fetchReq = req;
        end
        fetchSide = '0;
        if (e.collide) begin
            fetchSide.valid = 1'b1;
            fetchSide.size  = memCtrlPkg::sizeWord;
            fetchSide.addr  = {e.addr[`MEM_ADDR_W-1:2], 2'b00};
            fetchReq        = fetchSide;
        end
        awaitDone(e.isData, int'(e.stall), e.collide, cycles, gotData);
        assert (cycles == expCycles) else flagMismatch($sformatf(
            "done after %0d cycles at %h, expected %0d", cycles, e.addr, expCycles));
        if (e.write) begin
            modelWrite(e.addr, n, e.wdata);
        end else begin
            assert (gotData == expData) else flagMismatch($sformatf(
                "read %h from %h, expected %h", gotData, e.addr, expData));
        end
        @(negedge clk);
        if (e.isData) begin
            dataReq = '0;
        end else begin
            fetchReq = '0;
        end
        // the waiting fetch goes next and sees any store just made
        if (e.collide) begin
            expData = modelRead(fetchSide.addr, 4);
            awaitDone(1'b0, 0, 1'b0, cycles, gotData);
            assert (cycles == 5 && gotData == expData) else flagMismatch($sformatf(
                "fetch after collision gave %h in %0d cycles, expected %h", gotData, cycles,
                expData));
            @(negedge clk);
            fetchReq = '0;
        end
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("timeout: run stopped after %0d cycles", cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        rdy         = 1'b1;
        fetchReq    = '0;
        dataReq     = '0;
        valueErrors = 0;
        otherErrors = 0;
        cycleCount  = 0;
        cycleLimit  = 100;
        void'($urandom(32'hef78_65e2));
        buildTable();
        foreach (stimTable[i]) begin
            cycleLimit += 10 + 2 * int'(stimTable[i].stall);
        end
        @(negedge rst);
        repeat (3) begin
            assert (!fetchResp.done && !fetchResp.busy && !dataResp.done && !dataResp.busy)
                else flagMismatch("response active after reset");
            @(negedge clk);
        end
        foreach (stimTable[i]) begin
            runTransfer(stimTable[i]);
        end
        $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+logic
logic/memCtrlPkg.sv
logic/memPortArbiter.sv
logic/memByteSequencer.sv
logic/byteRam.sv
logic/memSubsystem.sv
verification/clockGen.sv
verification/memSubsystem_sva.sv
verification/memSubsystemTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= memSubsystemTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test passed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAILED: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAILED: run did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
